//--- files.f
busPkg.sv
devicePkg.sv
busDecoder.sv
dataMemory.sv
stopwatch.sv
lfsrDevice.sv
socTop.sv
tbClock.sv
tbSoc.sv

//--- Makefile
# Verilator build and run of the data bus subsystem testbench

SOURCES := $(shell cat files.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/VtbSoc: files.f $(SOURCES)
	verilator --binary --timing --top-module tbSoc -Mdir obj_dir -o VtbSoc -f files.f

run: obj_dir/VtbSoc
	./obj_dir/VtbSoc > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Result: FAILED" sim.log; then exit 1; fi
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tbSoc.sv
// Testbench for the data bus subsystem
// Random bus traffic from the master side, checked against a model of
// the memory, the LFSR and the stopwatch
module tbSoc;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int memWords     = 1024;
    localparam int tickDiv      = 25;
    localparam int clkPeriodNs  = 8;
    localparam int driveDelay   = 1;
    localparam int resetTimeout = 20;
    localparam int seed         = 96013;

    logic           clk;
    logic           rstN;
    logic           readEnable;
    logic           writeEnable;
    busPkg::byteEnT byteEnable;
    busPkg::addrT   address;
    busPkg::wordT   writeData;
    busPkg::wordT   readData;

    // Reference model
    busPkg::wordT memModel [memWords];
    bit           memValid [memWords];
    int           writtenIdx [$];
    busPkg::wordT lfsrModel;

    // Edge times of the most recent accesses
    time lastReadEdge;
    time lastWriteEdge;

    tbClock #(.periodNs(clkPeriodNs), .resetCycles(2)) clockGen (.iClk(clk), .rstN(rstN));

    socTop #(
        .memWords (memWords),
        .tickDiv  (tickDiv)
    ) dut (
        .iClk        (clk),
        .rstN        (rstN),
        .readEnable  (readEnable),
        .writeEnable (writeEnable),
        .byteEnable  (byteEnable),
        .address     (address),
        .writeData   (writeData),
        .readData    (readData)
    );

    task automatic stopOnFailure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // Bounded wait for reset release that ends just after an edge
    task automatic waitForReset();
        int cycles;
        cycles = 0;
        while (rstN !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > resetTimeout) begin
                $display("reset was not released within %0d cycles", resetTimeout);
                stopOnFailure();
            end
        end
        #driveDelay;
    endtask

    // Bus tasks start and end one drive delay after an edge
    task automatic writeBus(input busPkg::addrT addr, input busPkg::wordT data,
                            input busPkg::byteEnT lanes);
        address     = addr;
        writeData   = data;
        byteEnable  = lanes;
        writeEnable = 1'b1;
        @(posedge clk);
        lastWriteEdge = $time;
        #driveDelay;
        writeEnable = 1'b0;
    endtask

    task automatic readBus(input busPkg::addrT addr, output busPkg::wordT data);
        address    = addr;
        readEnable = 1'b1;
        @(posedge clk);
        lastReadEdge = $time;
        #driveDelay;
        readEnable = 1'b0;
        // One-cycle latency, sampled at the following edge
        @(posedge clk);
        data = readData;
        #driveDelay;
    endtask

    task automatic waitCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #driveDelay;
        end
    endtask

    function automatic busPkg::addrT memAddr(input int idx);
        return busPkg::memBase + busPkg::addrT'(idx) * 32'd4;
    endfunction

    // One Galois step with the taps folded in when a one falls out
    function automatic busPkg::wordT advanceLfsr(input busPkg::wordT s);
        busPkg::wordT shifted;
        shifted = s >> 1;
        if (s[0]) begin
            shifted = shifted ^ devicePkg::lfsrTaps;
        end
        return shifted;
    endfunction

    function automatic bit isMapped(input busPkg::addrT a);
        bit inMem;
        bit inSw;
        bit inLfsr;
        inMem  = (a >= busPkg::memBase) && (a < busPkg::memBase + busPkg::memSpan);
        inSw   = (a >= busPkg::stopwatchBase) &&
                 (a < busPkg::stopwatchBase + busPkg::periphSpan);
        inLfsr = (a >= busPkg::lfsrBase) && (a < busPkg::lfsrBase + busPkg::periphSpan);
        return inMem || inSw || inLfsr;
    endfunction

    // Either anywhere in the map or inside the peripheral page
    function automatic busPkg::addrT randomUnmapped(input bit nearPeriph);
        busPkg::addrT a;
        do begin
            if (nearPeriph) begin
                a = busPkg::mmioBase + busPkg::addrT'($urandom_range(1023, 0)) * 32'd4;
            end else begin
                a = $urandom & 32'hFFFF_FFFC;
            end
        end while (isMapped(a));
        return a;
    endfunction

    task automatic checkMemWord(input busPkg::addrT addr, input busPkg::wordT expected,
                                input busPkg::wordT actual);
        if (actual !== expected) begin
            $display("error at %0d ns: readData (memory %h) expected %h, actual %h",
                     $time, addr, expected, actual);
            stopOnFailure();
        end
    endtask

    task automatic checkLfsrWord(input busPkg::wordT expected, input busPkg::wordT actual);
        if (actual !== expected) begin
            $display("error at %0d ns: readData (lfsr) expected %h, actual %h",
                     $time, expected, actual);
            stopOnFailure();
        end
    endtask

    task automatic checkStopwatchCount(input busPkg::wordT lowest, input busPkg::wordT highest,
                                       input busPkg::wordT actual);
        if ($isunknown(actual) || actual < lowest || actual > highest) begin
            $display("error at %0d ns: readData (stopwatch) expected %0d..%0d, actual %0d",
                     $time, lowest, highest, actual);
            stopOnFailure();
        end
    endtask

    task automatic checkUnmapped(input busPkg::addrT addr, input busPkg::wordT actual);
        if (actual !== '0) begin
            $display("error at %0d ns: readData (unmapped %h) expected %h, actual %h",
                     $time, addr, 32'h0, actual);
            stopOnFailure();
        end
    endtask

    // Default seed, random seed, then the zero-seed fallback
    task automatic followLfsr();
        busPkg::wordT got;
        busPkg::wordT newSeed;
        lfsrModel = devicePkg::lfsrDefaultSeed;
        repeat (50) begin
            readBus(busPkg::lfsrBase, got);
            checkLfsrWord(lfsrModel, got);
            lfsrModel = advanceLfsr(lfsrModel);
        end
        newSeed = $urandom;
        if (newSeed == '0) begin
            newSeed = 32'h1;
        end
        writeBus(busPkg::lfsrBase, newSeed, 4'hF);
        lfsrModel = newSeed;
        repeat (50) begin
            readBus(busPkg::lfsrBase, got);
            checkLfsrWord(lfsrModel, got);
            lfsrModel = advanceLfsr(lfsrModel);
        end
        writeBus(busPkg::lfsrBase, '0, 4'hF);
        readBus(busPkg::lfsrBase, got);
        checkLfsrWord(devicePkg::lfsrDefaultSeed, got);
        lfsrModel = advanceLfsr(devicePkg::lfsrDefaultSeed);
    endtask

    // Full-word writes mixed with reads of words already written
    task automatic sweepMemoryWords();
        busPkg::wordT got;
        busPkg::wordT data;
        int idx;
        for (int i = 0; i < 300; i++) begin
            if (writtenIdx.size() == 0 || $urandom_range(1, 0) == 0) begin
                idx  = $urandom_range(memWords - 1, 0);
                data = $urandom;
                writeBus(memAddr(idx), data, 4'hF);
                memModel[idx] = data;
                if (!memValid[idx]) begin
                    memValid[idx] = 1'b1;
                    writtenIdx.push_back(idx);
                end
            end else begin
                idx = writtenIdx[$urandom_range(writtenIdx.size() - 1, 0)];
                readBus(memAddr(idx), got);
                checkMemWord(memAddr(idx), memModel[idx], got);
            end
        end
    endtask

    // Partial writes over known words and a read back the next cycle
    task automatic mergeByteLanes();
        busPkg::wordT   got;
        busPkg::wordT   data;
        busPkg::byteEnT lanes;
        int idx;
        repeat (100) begin
            idx   = writtenIdx[$urandom_range(writtenIdx.size() - 1, 0)];
            lanes = busPkg::byteEnT'($urandom_range(15, 0));
            data  = $urandom;
            writeBus(memAddr(idx), data, lanes);
            for (int lane = 0; lane < 4; lane++) begin
                if (lanes[lane]) begin
                    memModel[idx][lane*8 +: 8] = data[lane*8 +: 8];
                end
            end
            readBus(memAddr(idx), got);
            checkMemWord(memAddr(idx), memModel[idx], got);
        end
    endtask

    // Count is elapsed cycles over tickDiv with one tick of slack
    task automatic timeStopwatch();
        busPkg::wordT got;
        busPkg::wordT prev;
        time clearEdge;
        int elapsed;
        int high;
        int low;
        repeat (8) begin
            writeBus(busPkg::stopwatchBase, $urandom, 4'hF);
            clearEdge = lastWriteEdge;
            prev = '0;
            repeat (3) begin
                waitCycles($urandom_range(400, 0));
                readBus(busPkg::stopwatchBase, got);
                elapsed = int'((lastReadEdge - clearEdge) / clkPeriodNs);
                high    = elapsed / tickDiv;
                low     = (high > 0) ? high - 1 : 0;
                // Never below an earlier reading
                if (int'(prev) > low) begin
                    low = int'(prev);
                end
                checkStopwatchCount(busPkg::wordT'(low), busPkg::wordT'(high), got);
                prev = got;
            end
        end
        readBus(busPkg::stopwatchBase + 32'h4, got);
        checkUnmapped(busPkg::stopwatchBase + 32'h4, got);
    endtask

    // Holes in the map read zero and swallow writes
    task automatic probeUnmapped();
        busPkg::addrT edges [4];
        busPkg::addrT a;
        busPkg::wordT got;
        int idx;
        edges[0] = busPkg::memBase - 32'h4;
        edges[1] = busPkg::memBase + busPkg::memSpan;
        edges[2] = busPkg::mmioBase;
        edges[3] = busPkg::lfsrBase + busPkg::periphSpan;
        for (int i = 0; i < 44; i++) begin
            a = (i < 4) ? edges[i] : randomUnmapped(i[0]);
            writeBus(a, $urandom, 4'hF);
            readBus(a, got);
            checkUnmapped(a, got);
        end
        repeat (20) begin
            idx = writtenIdx[$urandom_range(writtenIdx.size() - 1, 0)];
            readBus(memAddr(idx), got);
            checkMemWord(memAddr(idx), memModel[idx], got);
        end
        readBus(busPkg::lfsrBase, got);
        checkLfsrWord(lfsrModel, got);
    endtask

    initial begin
        void'($urandom(seed));
        readEnable    = 1'b0;
        writeEnable   = 1'b0;
        byteEnable    = '0;
        address       = '0;
        writeData     = '0;
        lastReadEdge  = 0;
        lastWriteEdge = 0;
        waitForReset();
        // Return select starts at no device
        checkUnmapped(address, readData);
        followLfsr();
        sweepMemoryWords();
        mergeByteLanes();
        timeStopwatch();
        probeUnmapped();
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- tbClock.sv
// Testbench clock and reset source
// Free-running clock, active-low reset held for a fixed number of cycles
module tbClock #(
    parameter int periodNs    = 8,
    parameter int resetCycles = 2
) (
    output logic iClk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        iClk = 1'b0;
        forever #(periodNs / 2) iClk = ~iClk;
    end

    // Release lands just after an edge and away from the sampling point
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge iClk);
        #1 rstN = 1'b1;
    end

endmodule

//--- socTop.sv
// Data bus subsystem top level
// Bus decoder with data memory, stopwatch and LFSR devices
module socTop #(
    parameter int memWords = 1024,
    parameter int tickDiv  = 25
) (
    input  logic           iClk,
    input  logic           rstN,
    input  logic           readEnable,
    input  logic           writeEnable,
    input  busPkg::byteEnT byteEnable,
    input  busPkg::addrT   address,
    input  busPkg::wordT   writeData,
    output busPkg::wordT   readData
);

    // Decoder strobes
    logic memRead;
    logic memWrite;
    logic swRead;
    logic swWrite;
    logic lfsrRead;
    logic lfsrWrite;

    busPkg::offsetT localOffset;

    // Device read words
    busPkg::wordT memReadData;
    busPkg::wordT swReadData;
    busPkg::wordT lfsrReadData;

    busDecoder decoder0 (
        .iClk         (iClk),
        .rstN         (rstN),
        .readEnable   (readEnable),
        .writeEnable  (writeEnable),
        .address      (address),
        .memReadData  (memReadData),
        .swReadData   (swReadData),
        .lfsrReadData (lfsrReadData),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .swRead       (swRead),
        .swWrite      (swWrite),
        .lfsrRead     (lfsrRead),
        .lfsrWrite    (lfsrWrite),
        .localOffset  (localOffset),
        .readData     (readData)
    );

    dataMemory #(
        .memWords (memWords)
    ) memory0 (
        .iClk        (iClk),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .byteEnable  (byteEnable),
        .localOffset (localOffset),
        .writeData   (writeData),
        .memReadData (memReadData)
    );

    stopwatch #(
        .tickDiv (tickDiv)
    ) stopwatch0 (
        .iClk        (iClk),
        .rstN        (rstN),
        .swRead      (swRead),
        .swWrite     (swWrite),
        .localOffset (localOffset),
        .swReadData  (swReadData)
    );

    lfsrDevice lfsr0 (
        .iClk         (iClk),
        .rstN         (rstN),
        .lfsrRead     (lfsrRead),
        .lfsrWrite    (lfsrWrite),
        .localOffset  (localOffset),
        .writeData    (writeData),
        .lfsrReadData (lfsrReadData)
    );

endmodule

//--- lfsrDevice.sv
// Random source peripheral
// Seedable 32-bit Galois LFSR, one step per read of the data register
module lfsrDevice (
    input  logic           iClk,
    input  logic           rstN,
    input  logic           lfsrRead,
    input  logic           lfsrWrite,
    input  busPkg::offsetT localOffset,
    input  busPkg::wordT   writeData,
    output busPkg::wordT   lfsrReadData
);

    devicePkg::lfsrRegT lfsrReg;

    busPkg::wordT state;
    busPkg::wordT nextState;
    busPkg::wordT seed;

    assign lfsrReg = (localOffset == devicePkg::lfsrDataOffset) ?
                     devicePkg::lfsrData : devicePkg::lfsrReserved;

    // Shift right, fold taps back in when a one falls out
    assign nextState = state[0] ? ((state >> 1) ^ devicePkg::lfsrTaps) : (state >> 1);

    // All-zero state would lock up
    assign seed = (writeData == '0) ? devicePkg::lfsrDefaultSeed : writeData;

    always_ff @(posedge iClk or negedge rstN) begin
        if (!rstN) begin
            state <= devicePkg::lfsrDefaultSeed;
        end else if (lfsrWrite && lfsrReg == devicePkg::lfsrData) begin
            state <= seed;
        end else if (lfsrRead && lfsrReg == devicePkg::lfsrData) begin
            state <= nextState;
        end
    end

    // Current state goes out, then the register advances
    always_ff @(posedge iClk) begin
        if (lfsrRead) begin
            if (lfsrReg == devicePkg::lfsrData) begin
                lfsrReadData <= state;
            end else begin
                lfsrReadData <= '0;
            end
        end
    end

endmodule

//--- stopwatch.sv
// Stopwatch peripheral
// Prescaled 32-bit tick counter that software reads and clears
module stopwatch #(
    parameter int tickDiv = 25
) (
    input  logic           iClk,
    input  logic           rstN,
    input  logic           swRead,
    input  logic           swWrite,
    input  busPkg::offsetT localOffset,
    output busPkg::wordT   swReadData
);

    // Prescaler just wide enough for tickDiv-1
    localparam int preW = (tickDiv > 1) ? $clog2(tickDiv) : 1;
    localparam logic [preW-1:0] preLast = preW'(tickDiv - 1);

    devicePkg::swRegT swReg;

    logic [preW-1:0] prescale;
    busPkg::wordT    tickCount;
    logic            tick;

    // Register select from the local offset
    assign swReg = (localOffset == devicePkg::swCountOffset) ?
                   devicePkg::swCount : devicePkg::swReserved;

    // One tick per tickDiv clocks
    assign tick = (prescale == preLast);

    always_ff @(posedge iClk or negedge rstN) begin
        if (!rstN) begin
            prescale  <= '0;
            tickCount <= '0;
        end else if (swWrite && swReg == devicePkg::swCount) begin
            // Any write to the count restarts timing
            prescale  <= '0;
            tickCount <= '0;
        end else if (tick) begin
            prescale  <= '0;
            tickCount <= tickCount + 32'd1;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

    // Count as seen at the read edge
    always_ff @(posedge iClk) begin
        if (swRead) begin
            if (swReg == devicePkg::swCount) begin
                swReadData <= tickCount;
            end else begin
                swReadData <= '0;
            end
        end
    end

endmodule

//--- dataMemory.sv
// Data memory
// Word-wide RAM with byte-lane writes and a one-cycle registered read
module dataMemory #(
    parameter int memWords = 1024
) (
    input  logic           iClk,
    input  logic           memRead,
    input  logic           memWrite,
    input  busPkg::byteEnT byteEnable,
    input  busPkg::offsetT localOffset,
    input  busPkg::wordT   writeData,
    output busPkg::wordT   memReadData
);

    // Index width for the configured depth
    localparam int idxW = (memWords > 1) ? $clog2(memWords) : 1;

    busPkg::wordT mem [memWords];

    logic [9:0]      wordOffset;
    logic [idxW-1:0] wordIdx;
    logic            inRange;

    // Byte offset to word index
    assign wordOffset = localOffset[11:2];
    assign wordIdx    = idxW'(wordOffset);

    // Words past the configured depth are not backed
    assign inRange = (32'(wordOffset) < memWords);

    // Only enabled lanes change
    always_ff @(posedge iClk) begin
        if (memWrite && inRange) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byteEnable[lane]) begin
                    mem[wordIdx][lane*8 +: 8] <= writeData[lane*8 +: 8];
                end
            end
        end
    end

    // Whole word captured at the read edge
    // Holds its value between reads
    always_ff @(posedge iClk) begin
        if (memRead) begin
            if (inRange) begin
                memReadData <= mem[wordIdx];
            end else begin
                memReadData <= '0;
            end
        end
    end

endmodule

//--- busDecoder.sv
// Data bus address decoder
// Turns the bus strobes into per-device strobes and a local offset,
// and muxes the registered device read words back onto readData
module busDecoder (
    input  logic           iClk,
    input  logic           rstN,
    input  logic           readEnable,
    input  logic           writeEnable,
    input  busPkg::addrT   address,
    input  busPkg::wordT   memReadData,
    input  busPkg::wordT   swReadData,
    input  busPkg::wordT   lfsrReadData,
    output logic           memRead,
    output logic           memWrite,
    output logic           swRead,
    output logic           swWrite,
    output logic           lfsrRead,
    output logic           lfsrWrite,
    output busPkg::offsetT localOffset,
    output busPkg::wordT   readData
);

    // Exclusive window ends
    localparam busPkg::addrT memEnd       = busPkg::memBase + busPkg::memSpan;
    localparam busPkg::addrT stopwatchEnd = busPkg::stopwatchBase + busPkg::periphSpan;
    localparam busPkg::addrT lfsrEnd      = busPkg::lfsrBase + busPkg::periphSpan;

    busPkg::devSelT devSel;
    busPkg::devSelT readSel;
    busPkg::addrT   baseAddr;

    // Single address compare against the map
    always_comb begin
        devSel   = busPkg::devNone;
        baseAddr = address;
        if (address >= busPkg::memBase && address < memEnd) begin
            devSel   = busPkg::devMem;
            baseAddr = busPkg::memBase;
        end else if (address >= busPkg::stopwatchBase && address < stopwatchEnd) begin
            devSel   = busPkg::devStopwatch;
            baseAddr = busPkg::stopwatchBase;
        end else if (address >= busPkg::lfsrBase && address < lfsrEnd) begin
            devSel   = busPkg::devLfsr;
            baseAddr = busPkg::lfsrBase;
        end
    end

    // Unmapped accesses see offset zero
    assign localOffset = busPkg::offsetT'(address - baseAddr);

    // Per-device strobes
    assign memRead   = readEnable  && (devSel == busPkg::devMem);
    assign memWrite  = writeEnable && (devSel == busPkg::devMem);
    assign swRead    = readEnable  && (devSel == busPkg::devStopwatch);
    assign swWrite   = writeEnable && (devSel == busPkg::devStopwatch);
    assign lfsrRead  = readEnable  && (devSel == busPkg::devLfsr);
    assign lfsrWrite = writeEnable && (devSel == busPkg::devLfsr);

    // Remember who answers this read
    // Lines up with the device read registers
    always_ff @(posedge iClk or negedge rstN) begin
        if (!rstN) begin
            readSel <= busPkg::devNone;
        end else if (readEnable) begin
            readSel <= devSel;
        end
    end

    // Return mux
    always_comb begin
        case (readSel)
            busPkg::devMem:       readData = memReadData;
            busPkg::devStopwatch: readData = swReadData;
            busPkg::devLfsr:      readData = lfsrReadData;
            default:              readData = '0;
        endcase
    end

endmodule

//--- devicePkg.sv
// Peripheral register map and LFSR constants
// Used by the stopwatch, the LFSR and the testbench
package devicePkg;

    // Stopwatch registers
    typedef enum logic {
        swCount,
        swReserved
    } swRegT;

    // LFSR registers
    typedef enum logic {
        lfsrData,
        lfsrReserved
    } lfsrRegT;

    // Register offsets inside each device block
    localparam busPkg::offsetT swCountOffset = 12'h000;
    localparam busPkg::offsetT lfsrDataOffset = 12'h000;

    // Galois feedback mask applied when the shifted-out bit is one
    localparam busPkg::wordT lfsrTaps = 32'h8020_0003;

    // Used after reset and whenever software writes a zero seed
    localparam busPkg::wordT lfsrDefaultSeed = 32'hACE1_ACE1;

endpackage

//--- busPkg.sv
// Data bus types and address map
// Shared by the bus decoder, the top level and the testbench
package busPkg;

    // One bus data word
    typedef logic [31:0] wordT;

    // Full byte address as driven by the bus master
    typedef logic [31:0] addrT;

    // One enable bit per byte lane
    typedef logic [3:0] byteEnT;

    // Device-local byte offset
    typedef logic [11:0] offsetT;

    // Which device a bus access lands on
    typedef enum logic [1:0] {
        devMem,
        devStopwatch,
        devLfsr,
        devNone
    } devSelT;

    // Data segment
    localparam addrT memBase = 32'h1001_0000;
    localparam addrT memSpan = 32'h0000_1000;

    // Peripheral window
    localparam addrT mmioBase = 32'hFF20_0000;

    // Each peripheral owns a small register block
    localparam addrT periphSpan = 32'h0000_0010;

    localparam addrT stopwatchBase = mmioBase + 32'h0000_0510;
    localparam addrT lfsrBase      = mmioBase + 32'h0000_0520;

endpackage
